// File: design/csi2_proto_pkg.sv
package csi2_proto_pkg;

  // ##############################
  // packet header fields.
  // ##############################

  // byte 0 is the data identifier, bytes 1 and 2 the word count.
  typedef logic [23:0] hdr_t;

  // the ECC byte carries six parity bits, the two upper bits stay zero.
  typedef logic [5:0] ecc_t;

  // virtual channel sits above this in byte 0.
  typedef logic [5:0] data_type_t;

  typedef logic [15:0] word_cnt_t;

  // ##############################
  // codes and constants.
  // ##############################

  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  localparam data_type_t DT_FRAME_START = 6'h00;
  localparam data_type_t DT_FRAME_END   = 6'h01;
  localparam data_type_t DT_LONG_MIN    = 6'h10;

  // parity bit k is the even parity of the header bits in mask k.
  localparam hdr_t ECC_MASK [6] = '{
    24'hF12CB7,
    24'hF2555B,
    24'h749A6D,
    24'hB8E38E,
    24'hDF03F0,
    24'hEFFC00
  };

endpackage

// File: design/csi2_rx_pkg.sv
package csi2_rx_pkg;

  localparam int NUM_LANES = 4;

  // one byte per lane, lane 0 in the low byte.
  typedef logic [NUM_LANES*8-1:0] word_t;

  typedef logic [NUM_LANES-1:0] strb_t;

  // ##############################
  // packet parser states.
  // ##############################

  typedef enum logic [1:0] {
    IDLE,
    PAYLOAD,
    DISCARD
  } parser_state_t;

endpackage

// File: design/csi2_lane_merger.sv
`timescale 1ns/10ps

module csi2_lane_merger (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [csi2_rx_pkg::NUM_LANES-1:0][7:0]  lane_data_i,
  input  logic                                    lane_valid_i,
  output csi2_rx_pkg::word_t                      word_o,
  output logic                                    word_valid_o,
  output logic                                    pkt_done_o
);

  logic lane_valid_d;
  logic burst_ok;
  logic sync_ok;

  // every lane must lead with the sync byte.
  always_comb begin
    sync_ok = 1'b1;
    for (int i = 0; i < csi2_rx_pkg::NUM_LANES; i++) begin
      if (lane_data_i[i] != csi2_proto_pkg::SYNC_BYTE) begin
        sync_ok = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lane_valid_d <= 1'b0;
      burst_ok     <= 1'b0;
      word_valid_o <= 1'b0;
      pkt_done_o   <= 1'b0;
    end else begin
      lane_valid_d <= lane_valid_i;
      // the sync cycle itself carries no data.
      if (lane_valid_i && !lane_valid_d) begin
        burst_ok <= sync_ok;
      end
      word_valid_o <= lane_valid_i && lane_valid_d && burst_ok;
      pkt_done_o   <= !lane_valid_i && lane_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    word_o <= lane_data_i;
  end

  a_lane_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_valid_i |-> !$isunknown(lane_data_i));

endmodule

// File: design/csi2_hamming_dec.sv
`timescale 1ns/10ps

module csi2_hamming_dec (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  csi2_rx_pkg::word_t data_i,
  input  logic               valid_i,
  input  logic               pkt_done_i,
  output csi2_rx_pkg::word_t data_o,
  output logic               valid_o,
  output logic               pkt_done_o,
  output logic               error_o,
  output logic               error_corrected_o
);

  logic                 first_word;
  csi2_proto_pkg::hdr_t hdr;
  csi2_proto_pkg::ecc_t ecc_rx;
  csi2_proto_pkg::ecc_t syndrome;
  csi2_rx_pkg::word_t   fixed_word;
  logic                 hit;

  assign hdr    = data_i[23:0];
  assign ecc_rx = data_i[29:24];

  always_comb begin
    for (int k = 0; k < 6; k++) begin
      syndrome[k] = ecc_rx[k] ^ (^(hdr & csi2_proto_pkg::ECC_MASK[k]));
    end
  end

  // ##############################
  // single bit correction.
  // ##############################

  always_comb begin : fix_blk
    csi2_proto_pkg::ecc_t col;
    fixed_word = data_i;
    hit        = 1'b0;
    for (int i = 0; i < 24; i++) begin
      for (int k = 0; k < 6; k++) begin
        col[k] = csi2_proto_pkg::ECC_MASK[k][i];
      end
      if (col == syndrome) begin
        fixed_word[i] = ~data_i[i];
        hit           = 1'b1;
      end
    end
    // a one-hot syndrome points at the ECC byte itself.
    for (int k = 0; k < 6; k++) begin
      if (syndrome == csi2_proto_pkg::ecc_t'(1 << k)) begin
        fixed_word[24+k] = ~data_i[24+k];
        hit              = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      first_word        <= 1'b1;
      valid_o           <= 1'b0;
      pkt_done_o        <= 1'b0;
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end else begin
      if (pkt_done_i) begin
        first_word <= 1'b1;
      end else if (valid_i) begin
        first_word <= 1'b0;
      end
      valid_o           <= valid_i;
      pkt_done_o        <= pkt_done_i;
      error_o           <= valid_i && first_word && (syndrome != '0) && !hit;
      error_corrected_o <= valid_i && first_word && (syndrome != '0) && hit;
    end
  end

  always_ff @(posedge clk_i) begin
    data_o <= (valid_i && first_word) ? fixed_word : data_i;
  end

  a_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(error_o && error_corrected_o));

endmodule

// File: design/csi2_pkt_parser.sv
`timescale 1ns/10ps

module csi2_pkt_parser (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  csi2_rx_pkg::word_t         data_i,
  input  logic                       valid_i,
  input  logic                       pkt_done_i,
  input  logic                       hdr_err_i,
  output logic                       hdr_valid_o,
  output csi2_proto_pkg::data_type_t data_type_o,
  output csi2_proto_pkg::word_cnt_t  word_cnt_o,
  output csi2_rx_pkg::word_t         pl_data_o,
  output csi2_rx_pkg::strb_t         pl_strb_o,
  output logic                       pl_last_o,
  output logic                       pl_valid_o
);

  csi2_rx_pkg::parser_state_t state;
  csi2_proto_pkg::word_cnt_t  remaining;
  csi2_proto_pkg::data_type_t hdr_dt;
  csi2_proto_pkg::word_cnt_t  hdr_wc;
  csi2_rx_pkg::strb_t         last_strb;
  logic                       last_word;

  assign hdr_dt    = data_i[5:0];
  assign hdr_wc    = data_i[23:8];
  assign last_word = remaining <= 16'd4;

  // low (word count mod 4) bytes, or the whole word.
  always_comb begin
    case (remaining[1:0])
      2'd1:    last_strb = 4'b0001;
      2'd2:    last_strb = 4'b0011;
      2'd3:    last_strb = 4'b0111;
      default: last_strb = 4'b1111;
    endcase
  end

  // ##############################
  // control FSM.
  // ##############################

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state       <= csi2_rx_pkg::IDLE;
      remaining   <= '0;
      hdr_valid_o <= 1'b0;
      pl_valid_o  <= 1'b0;
      pl_last_o   <= 1'b0;
    end else begin
      hdr_valid_o <= 1'b0;
      pl_valid_o  <= 1'b0;
      pl_last_o   <= 1'b0;
      if (pkt_done_i) begin
        state <= csi2_rx_pkg::IDLE;
      end else if (valid_i) begin
        case (state)
          csi2_rx_pkg::IDLE: begin
            state <= csi2_rx_pkg::DISCARD;
            if (!hdr_err_i) begin
              hdr_valid_o <= 1'b1;
              if (hdr_dt >= csi2_proto_pkg::DT_LONG_MIN && hdr_wc != '0) begin
                state     <= csi2_rx_pkg::PAYLOAD;
                remaining <= hdr_wc;
              end
            end
          end
          csi2_rx_pkg::PAYLOAD: begin
            pl_valid_o <= 1'b1;
            if (last_word) begin
              pl_last_o <= 1'b1;
              state     <= csi2_rx_pkg::DISCARD;
            end else begin
              remaining <= remaining - 16'd4;
            end
          end
          default: begin
            // footer and padding.
            state <= csi2_rx_pkg::DISCARD;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && state == csi2_rx_pkg::IDLE) begin
      data_type_o <= hdr_dt;
      word_cnt_o  <= hdr_wc;
    end
    if (valid_i && state == csi2_rx_pkg::PAYLOAD) begin
      pl_data_o <= data_i;
      pl_strb_o <= last_word ? last_strb : '1;
    end
  end

  a_hdr_pl_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pl_valid_o && hdr_valid_o));

endmodule

// File: design/csi2_frame_tracker.sv
`timescale 1ns/10ps

module csi2_frame_tracker (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       hdr_valid_i,
  input  csi2_proto_pkg::data_type_t data_type_i,
  input  csi2_proto_pkg::word_cnt_t  word_cnt_i,
  input  csi2_rx_pkg::word_t         pl_data_i,
  input  csi2_rx_pkg::strb_t         pl_strb_i,
  input  logic                       pl_last_i,
  input  logic                       pl_valid_i,
  output logic                       frame_start_o,
  output logic                       frame_end_o,
  output csi2_proto_pkg::word_cnt_t  frame_num_o,
  output csi2_rx_pkg::word_t         pix_data_o,
  output csi2_rx_pkg::strb_t         pix_strb_o,
  output logic                       pix_last_o,
  output logic                       pix_valid_o
);

  logic in_frame;
  logic is_fs;
  logic is_fe;

  assign is_fs = hdr_valid_i && data_type_i == csi2_proto_pkg::DT_FRAME_START;
  assign is_fe = hdr_valid_i && data_type_i == csi2_proto_pkg::DT_FRAME_END;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_frame      <= 1'b0;
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      frame_num_o   <= '0;
      pix_valid_o   <= 1'b0;
      pix_last_o    <= 1'b0;
    end else begin
      frame_start_o <= is_fs;
      frame_end_o   <= is_fe;
      if (is_fs) begin
        in_frame    <= 1'b1;
        frame_num_o <= word_cnt_i;
      end else if (is_fe) begin
        in_frame <= 1'b0;
      end
      // payload outside a frame is dropped.
      pix_valid_o <= pl_valid_i && in_frame;
      pix_last_o  <= pl_valid_i && pl_last_i && in_frame;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pl_valid_i) begin
      pix_data_o <= pl_data_i;
      pix_strb_o <= pl_strb_i;
    end
  end

  a_fs_fe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(frame_start_o && frame_end_o));

endmodule

// File: design/csi2_rx.sv
`timescale 1ns/10ps

module csi2_rx (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [csi2_rx_pkg::NUM_LANES-1:0][7:0]  lane_data_i,
  input  logic                                    lane_valid_i,
  output logic                                    frame_start_o,
  output logic                                    frame_end_o,
  output csi2_proto_pkg::word_cnt_t               frame_num_o,
  output csi2_rx_pkg::word_t                      pix_data_o,
  output csi2_rx_pkg::strb_t                      pix_strb_o,
  output logic                                    pix_last_o,
  output logic                                    pix_valid_o,
  output logic                                    hdr_fixed_o,
  output logic                                    hdr_err_o
);

  csi2_rx_pkg::word_t         mrg_word;
  logic                       mrg_valid;
  logic                       mrg_done;
  csi2_rx_pkg::word_t         dec_word;
  logic                       dec_valid;
  logic                       dec_done;
  logic                       hdr_valid;
  csi2_proto_pkg::data_type_t data_type;
  csi2_proto_pkg::word_cnt_t  word_cnt;
  csi2_rx_pkg::word_t         pl_data;
  csi2_rx_pkg::strb_t         pl_strb;
  logic                       pl_last;
  logic                       pl_valid;

  csi2_lane_merger merger0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lane_data_i  (lane_data_i),
    .lane_valid_i (lane_valid_i),
    .word_o       (mrg_word),
    .word_valid_o (mrg_valid),
    .pkt_done_o   (mrg_done)
  );

  // header errors leave here, two cycles ahead of the tracker.
  csi2_hamming_dec dec0 (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .data_i            (mrg_word),
    .valid_i           (mrg_valid),
    .pkt_done_i        (mrg_done),
    .data_o            (dec_word),
    .valid_o           (dec_valid),
    .pkt_done_o        (dec_done),
    .error_o           (hdr_err_o),
    .error_corrected_o (hdr_fixed_o)
  );

  csi2_pkt_parser parser0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .data_i      (dec_word),
    .valid_i     (dec_valid),
    .pkt_done_i  (dec_done),
    .hdr_err_i   (hdr_err_o),
    .hdr_valid_o (hdr_valid),
    .data_type_o (data_type),
    .word_cnt_o  (word_cnt),
    .pl_data_o   (pl_data),
    .pl_strb_o   (pl_strb),
    .pl_last_o   (pl_last),
    .pl_valid_o  (pl_valid)
  );

  csi2_frame_tracker tracker0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .hdr_valid_i   (hdr_valid),
    .data_type_i   (data_type),
    .word_cnt_i    (word_cnt),
    .pl_data_i     (pl_data),
    .pl_strb_i     (pl_strb),
    .pl_last_i     (pl_last),
    .pl_valid_i    (pl_valid),
    .frame_start_o (frame_start_o),
    .frame_end_o   (frame_end_o),
    .frame_num_o   (frame_num_o),
    .pix_data_o    (pix_data_o),
    .pix_strb_o    (pix_strb_o),
    .pix_last_o    (pix_last_o),
    .pix_valid_o   (pix_valid_o)
  );

endmodule

// File: verification/csi2_rx_tb.sv
`timescale 1ns/10ps

module csi2_rx_tb;

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  logic [csi2_rx_pkg::NUM_LANES-1:0][7:0] lane_data;
  logic                                   lane_valid;
  logic                                   frame_start;
  logic                                   frame_end;
  csi2_proto_pkg::word_cnt_t              frame_num;
  csi2_rx_pkg::word_t                     pix_data;
  csi2_rx_pkg::strb_t                     pix_strb;
  logic                                   pix_last;
  logic                                   pix_valid;
  logic                                   hdr_fixed;
  logic                                   hdr_err;

  // one entry per line of the test file.
  string       test_name[$];
  logic [5:0]  test_dt[$];
  int          test_wc[$];
  logic [31:0] test_flip[$];
  int          test_bad_sync[$];
  string       test_expect[$];

  // expected outputs, in the order the DUT must produce them.
  logic [15:0] fs_num_q[$];
  string       fs_name_q[$];
  string       fe_q[$];
  logic [31:0] pix_data_q[$];
  logic [3:0]  pix_strb_q[$];
  bit          pix_last_q[$];
  string       pix_name_q[$];
  string       fixed_q[$];
  string       err_q[$];

  integer seed;
  bit     in_frame_model;
  int     cycle_cnt = 0;
  int     cycle_limit = 100;
  int     drain;

  csi2_rx dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .lane_data_i   (lane_data),
    .lane_valid_i  (lane_valid),
    .frame_start_o (frame_start),
    .frame_end_o   (frame_end),
    .frame_num_o   (frame_num),
    .pix_data_o    (pix_data),
    .pix_strb_o    (pix_strb),
    .pix_last_o    (pix_last),
    .pix_valid_o   (pix_valid),
    .hdr_fixed_o   (hdr_fixed),
    .hdr_err_o     (hdr_err)
  );

  always #20 clk = ~clk;

  // ##############################
  // helpers.
  // ##############################

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp_val, input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("ERR %s: %s expected %h, actual %h", name, what, exp_val, act_val));
    end
  endtask

  function automatic logic [7:0] calc_ecc(input logic [23:0] hdr);
    logic [7:0] e;
    e = 8'h00;
    for (int k = 0; k < 6; k++) begin
      e[k] = ^(hdr & csi2_proto_pkg::ECC_MASK[k]);
    end
    return e;
  endfunction

  function automatic logic [31:0] strb_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[i*8 +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

  // scanned names are right aligned with zero bytes in front.
  function automatic string to_str(input logic [8*32-1:0] v);
    string s;
    s = "";
    for (int i = 31; i >= 0; i--) begin
      if (v[i*8 +: 8] != 8'h00) begin
        s = {s, $sformatf("%c", v[i*8 +: 8])};
      end
    end
    return s;
  endfunction

  function automatic int pending_count();
    return fs_num_q.size() + fe_q.size() + pix_data_q.size() + fixed_q.size() + err_q.size();
  endfunction

  task automatic load_tests();
    int               fd;
    int               n;
    int               total;
    int               words;
    logic [8*160-1:0] line_v;
    logic [8*32-1:0]  name_v;
    logic [8*32-1:0]  exp_v;
    logic [7:0]       dt_v;
    int               wc_v;
    logic [31:0]      flip_v;
    int               sync_v;
    fd = $fopen("verification/csi2_rx_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verification/csi2_rx_tests.txt");
    end else begin
      // two column description lines lead the file.
      n = $fgets(line_v, fd);
      n = $fgets(line_v, fd);
      total = 0;
      n = $fscanf(fd, "%s %h %d %h %d %s", name_v, dt_v, wc_v, flip_v, sync_v, exp_v);
      while (n == 6) begin
        test_name.push_back(to_str(name_v));
        test_dt.push_back(dt_v[5:0]);
        test_wc.push_back(wc_v);
        test_flip.push_back(flip_v);
        test_bad_sync.push_back(sync_v);
        test_expect.push_back(to_str(exp_v));
        // sync, header, payload with footer, two idle cycles.
        words = (dt_v[5:0] >= csi2_proto_pkg::DT_LONG_MIN) ? 1 + (wc_v + 5) / 4 : 1;
        total += words + 3;
        n = $fscanf(fd, "%s %h %d %h %d %s", name_v, dt_v, wc_v, flip_v, sync_v, exp_v);
      end
      $fclose(fd);
      cycle_limit = 2 * total + 100;
    end
  endtask

  // ##############################
  // packet build and drive.
  // ##############################

  task automatic run_test(input int idx);
    logic [7:0]  bytes[$];
    logic [15:0] wc;
    logic [23:0] hdr;
    logic [31:0] hdr_word;
    logic [3:0]  strb;
    string       name;
    bit          is_long;
    int          nwords;
    int          rem;
    int          base;
    name     = test_name[idx];
    wc       = 16'(test_wc[idx]);
    is_long  = test_dt[idx] >= csi2_proto_pkg::DT_LONG_MIN;
    hdr      = {wc, 2'b00, test_dt[idx]};
    hdr_word = {calc_ecc(hdr), hdr} ^ test_flip[idx];
    for (int i = 0; i < 4; i++) begin
      bytes.push_back(hdr_word[i*8 +: 8]);
    end
    if (is_long) begin
      for (int i = 0; i < test_wc[idx]; i++) begin
        bytes.push_back(8'($random(seed)));
      end
      bytes.push_back(8'h00);
      bytes.push_back(8'h00);
      while (bytes.size() % 4 != 0) begin
        bytes.push_back(8'h00);
      end
    end

    if (test_expect[idx] == "fixed") begin
      fixed_q.push_back(name);
    end
    if (test_expect[idx] == "dropped" && test_bad_sync[idx] == 0) begin
      err_q.push_back(name);
    end
    if (test_expect[idx] != "dropped") begin
      if (test_dt[idx] == csi2_proto_pkg::DT_FRAME_START) begin
        in_frame_model = 1'b1;
        fs_num_q.push_back(wc);
        fs_name_q.push_back(name);
      end else if (test_dt[idx] == csi2_proto_pkg::DT_FRAME_END) begin
        in_frame_model = 1'b0;
        fe_q.push_back(name);
      end else if (is_long && in_frame_model) begin
        nwords = (test_wc[idx] + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
          base = 4 + 4 * w;
          rem  = test_wc[idx] - 4 * w;
          strb = (rem >= 4) ? 4'hf : 4'((1 << rem) - 1);
          pix_data_q.push_back({bytes[base+3], bytes[base+2], bytes[base+1], bytes[base]});
          pix_strb_q.push_back(strb);
          pix_last_q.push_back(w == nwords - 1);
          pix_name_q.push_back(name);
        end
      end
    end

    @(negedge clk);
    lane_valid = 1'b1;
    for (int i = 0; i < csi2_rx_pkg::NUM_LANES; i++) begin
      lane_data[i] = csi2_proto_pkg::SYNC_BYTE;
    end
    if (test_bad_sync[idx] != 0) begin
      lane_data[2] = 8'hB9;
    end
    for (int c = 0; c < bytes.size() / 4; c++) begin
      @(negedge clk);
      for (int i = 0; i < csi2_rx_pkg::NUM_LANES; i++) begin
        lane_data[i] = bytes[4*c + i];
      end
    end
    @(negedge clk);
    lane_valid = 1'b0;
    lane_data  = '0;
    @(negedge clk);
  endtask

  // ##############################
  // output monitor.
  // ##############################

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout: run still busy after %0d cycles", cycle_cnt));
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (frame_start) begin
        if (fs_num_q.size() == 0) begin
          abort_run("frame_start_o pulsed where no frame start was expected");
        end else begin
          check_value(fs_name_q[0], "frame_num_o", 32'(fs_num_q[0]), 32'(frame_num));
          void'(fs_num_q.pop_front());
          void'(fs_name_q.pop_front());
        end
      end
      if (frame_end) begin
        if (fe_q.size() == 0) begin
          abort_run("frame_end_o pulsed where no frame end was expected");
        end else begin
          void'(fe_q.pop_front());
        end
      end
      if (pix_valid) begin
        if (pix_data_q.size() == 0) begin
          abort_run("pix_valid_o raised where no pixel word was expected");
        end else begin
          check_value(pix_name_q[0], "pix_strb_o", 32'(pix_strb_q[0]), 32'(pix_strb));
          check_value(pix_name_q[0], "pix_last_o", 32'(pix_last_q[0]), 32'(pix_last));
          check_value(pix_name_q[0], "pix_data_o",
                      pix_data_q[0] & strb_mask(pix_strb_q[0]),
                      pix_data & strb_mask(pix_strb_q[0]));
          void'(pix_data_q.pop_front());
          void'(pix_strb_q.pop_front());
          void'(pix_last_q.pop_front());
          void'(pix_name_q.pop_front());
        end
      end
      if (hdr_fixed) begin
        if (fixed_q.size() == 0) begin
          abort_run("hdr_fixed_o pulsed for a header that needed no correction");
        end else begin
          void'(fixed_q.pop_front());
        end
      end
      if (hdr_err) begin
        if (err_q.size() == 0) begin
          abort_run("hdr_err_o pulsed for a header that should have been accepted");
        end else begin
          void'(err_q.pop_front());
        end
      end
    end
  end

  initial begin
    seed           = 32'hfa2a_1ec4;
    in_frame_model = 1'b0;
    rst_n          = 1'b0;
    lane_valid     = 1'b0;
    lane_data      = '0;
    load_tests();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < test_name.size(); i++) begin
      run_test(i);
    end
    // the pipeline is four cycles deep.
    drain = 0;
    while (pending_count() != 0 && drain < 8) begin
      @(negedge clk);
      drain++;
    end
    repeat (6) @(negedge clk);
    if (test_name.size() == 0 || pending_count() != 0) begin
      $display("missing: %0d frame starts, %0d frame ends, %0d pixel words, %0d fixed, %0d errors",
               fs_num_q.size(), fe_q.size(), pix_data_q.size(), fixed_q.size(), err_q.size());
      abort_run("expected outputs never appeared, or the test file held no tests");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: verification/csi2_rx_tests.txt
# name  data_type(hex)  word_count(dec)  header_flip_mask(hex)  bad_sync(0/1)  expect
# expect is ok, fixed or dropped; the flip mask applies to the 32-bit header word.
long_before_fs   2B  8     00000000  0  ok
fs_frame1        00  1     00000000  0  ok
long_wc4         2B  4     00000000  0  ok
long_wc5         2B  5     00000000  0  ok
long_wc6         2B  6     00000000  0  ok
long_wc7         2B  7     00000000  0  ok
long_wc64        2A  64    00000000  0  ok
fix_wc_bit       2B  8     00000200  0  fixed
fix_ecc_bit      2B  12    04000000  0  fixed
fix_dt_bit       2C  6     00000004  0  fixed
err_dt_bits      2B  8     00000003  0  dropped
after_err        2B  9     00000000  0  ok
err_wc_bits      2A  16    00030000  0  dropped
bad_sync_long    2B  8     00000000  1  dropped
after_sync       2B  3     00000000  0  ok
generic_short    08  4660  00000000  0  ok
long_wc1         2B  1     00000000  0  ok
long_wc2         2B  2     00000000  0  ok
fe_frame1        01  1     00000000  0  ok
long_outside     2B  8     00000000  0  ok
fix_fs_bit       00  2     00000100  0  fixed
long_wc13        2C  13    00000000  0  ok
fe_frame2        01  2     00000000  0  ok
err_fs_bits      00  3     00000003  0  dropped
long_after_drop  2B  4     00000000  0  ok
bad_sync_fs      00  4     00000000  1  dropped
long_no_fs       2B  5     00000000  0  ok
fs_frame4        00  5     00000000  0  ok
long_wc10        2B  10    00000000  0  ok
fix_fe_ecc       01  5     20000000  0  fixed

// File: sources.f
design/csi2_proto_pkg.sv
design/csi2_rx_pkg.sv
design/csi2_lane_merger.sv
design/csi2_hamming_dec.sv
design/csi2_pkt_parser.sv
design/csi2_frame_tracker.sv
design/csi2_rx.sv
verification/csi2_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps -f sources.f \
  --top-module csi2_rx_tb -o csi2_rx_sim \
  && ./obj_dir/csi2_rx_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
